// File: hw/ex_pkg.sv
package ex_pkg;

    // ====================
    // widths
    // ====================
    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int dword_width    = 64;
    localparam int shamt_width    = 5;

    // ====================
    // operation codes
    // ====================
    typedef enum logic [7:0] {
        op_nop   = 8'd0,
        op_and   = 8'd1,
        op_or    = 8'd2,
        op_xor   = 8'd3,
        op_nor   = 8'd4,
        op_sll   = 8'd5,
        op_srl   = 8'd6,
        op_sra   = 8'd7,
        op_add   = 8'd8,
        op_addu  = 8'd9,
        op_sub   = 8'd10,
        op_subu  = 8'd11,
        op_slt   = 8'd12,
        op_sltu  = 8'd13,
        op_clz   = 8'd14,
        op_clo   = 8'd15,
        op_mul   = 8'd16,
        op_mult  = 8'd17,
        op_multu = 8'd18,
        op_mfhi  = 8'd19,
        op_mflo  = 8'd20,
        op_mthi  = 8'd21,
        op_mtlo  = 8'd22,
        op_movz  = 8'd23,
        op_movn  = 8'd24
    } alu_op_e;

    typedef enum logic [2:0] {
        grp_none  = 3'd0,
        grp_logic = 3'd1,
        grp_shift = 3'd2,
        grp_move  = 3'd3,
        grp_arith = 3'd4,
        grp_mul   = 3'd5
    } res_group_e;

    // which unit supplies the register write data
    function automatic res_group_e op_group(input alu_op_e op);
        case (op)
            op_and, op_or, op_xor, op_nor: op_group = grp_logic;
            op_sll, op_srl, op_sra: op_group = grp_shift;
            op_add, op_addu, op_sub, op_subu: op_group = grp_arith;
            op_slt, op_sltu, op_clz, op_clo: op_group = grp_arith;
            op_mul: op_group = grp_mul;
            op_mfhi, op_mflo, op_movz, op_movn: op_group = grp_move;
            default: op_group = grp_none;         // mult, multu, mthi, mtlo, nop
        endcase
    endfunction

endpackage

// File: hw/ex_arith.sv
module ex_arith
    import ex_pkg::*;
(
    input  alu_op_e               op,
    input  logic [word_width-1:0] reg1,
    input  logic [word_width-1:0] reg2,
    output logic [word_width-1:0] arith_res,
    output logic                  overflow
);

    logic                  negate;
    logic [word_width-1:0] reg2_mux;
    logic [word_width-1:0] sum;
    logic                  lt_signed;
    logic                  lt_unsigned;

    function automatic logic [word_width-1:0] lead_zeros(input logic [word_width-1:0] v);
        logic [word_width-1:0] n;
        logic                  found;
        n     = '0;
        found = 1'b0;
        for (int i = word_width - 1; i >= 0; i--) begin
            if (v[i]) begin
                found = 1'b1;
            end else if (!found) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign negate   = (op == op_sub) || (op == op_subu) || (op == op_slt);
    assign reg2_mux = negate ? (~reg2 + 1'b1) : reg2;   // two's complement for subtract
    assign sum      = reg1 + reg2_mux;

    // same operand signs, result sign flipped
    assign overflow = (reg1[word_width-1] == reg2_mux[word_width-1]) &&
                      (sum[word_width-1] != reg1[word_width-1]);

    assign lt_signed = (reg1[word_width-1] && !reg2[word_width-1]) ||
                       ((reg1[word_width-1] == reg2[word_width-1]) && sum[word_width-1]);
    assign lt_unsigned = reg1 < reg2;

    always_comb begin
        case (op)
            op_add, op_addu, op_sub, op_subu: arith_res = sum;
            op_slt:  arith_res = {{(word_width-1){1'b0}}, lt_signed};
            op_sltu: arith_res = {{(word_width-1){1'b0}}, lt_unsigned};
            op_clz:  arith_res = lead_zeros(reg1);
            op_clo:  arith_res = lead_zeros(~reg1);     // leading ones as zeros of inverse
            default: arith_res = '0;
        endcase
    end

endmodule

// File: hw/ex_bitwise.sv
module ex_bitwise
    import ex_pkg::*;
(
    input  alu_op_e               op,
    input  logic [word_width-1:0] reg1,
    input  logic [word_width-1:0] reg2,
    output logic [word_width-1:0] bit_res
);

    logic [shamt_width-1:0] shamt;
    logic [word_width-1:0]  logic_res;
    logic [word_width-1:0]  shift_res;

    assign shamt = reg1[shamt_width-1:0];

    always_comb begin
        case (op)
            op_and:  logic_res = reg1 & reg2;
            op_or:   logic_res = reg1 | reg2;
            op_xor:  logic_res = reg1 ^ reg2;
            op_nor:  logic_res = ~(reg1 | reg2);
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (op)
            op_sll:  shift_res = reg2 << shamt;
            op_srl:  shift_res = reg2 >> shamt;
            op_sra:  shift_res = $signed(reg2) >>> shamt;  // sign fill
            default: shift_res = '0;
        endcase
    end

    assign bit_res = (op_group(op) == grp_shift) ? shift_res : logic_res;

endmodule

// File: hw/ex_mul.sv
module ex_mul
    import ex_pkg::*;
(
    input  alu_op_e                op,
    input  logic [word_width-1:0]  reg1,
    input  logic [word_width-1:0]  reg2,
    output logic [dword_width-1:0] product
);

    logic                   is_signed;
    logic [word_width-1:0]  mag1;
    logic [word_width-1:0]  mag2;
    logic [dword_width-1:0] mag_prod;

    assign is_signed = (op == op_mul) || (op == op_mult);

    assign mag1 = (is_signed && reg1[word_width-1]) ? (~reg1 + 1'b1) : reg1;
    assign mag2 = (is_signed && reg2[word_width-1]) ? (~reg2 + 1'b1) : reg2;

    assign mag_prod = dword_width'(mag1) * dword_width'(mag2);

    // restore sign when operand signs differ
    assign product = (is_signed && (reg1[word_width-1] ^ reg2[word_width-1])) ?
                     (~mag_prod + 1'b1) : mag_prod;

endmodule

// File: hw/ex_hilo.sv
module ex_hilo
    import ex_pkg::*;
(
    input  alu_op_e                op,
    input  logic [word_width-1:0]  reg1,
    input  logic [dword_width-1:0] product,
    input  logic                   mem_whilo,
    input  logic [word_width-1:0]  mem_hi,
    input  logic [word_width-1:0]  mem_lo,
    input  logic                   wb_whilo,
    input  logic [word_width-1:0]  wb_hi,
    input  logic [word_width-1:0]  wb_lo,
    input  logic [word_width-1:0]  hi,
    input  logic [word_width-1:0]  lo,
    output logic [word_width-1:0]  move_res,
    output logic                   whilo,
    output logic [word_width-1:0]  hi_next,
    output logic [word_width-1:0]  lo_next
);

    logic [word_width-1:0] cur_hi;
    logic [word_width-1:0] cur_lo;

    // newest value wins
    always_comb begin
        if (mem_whilo) begin
            {cur_hi, cur_lo} = {mem_hi, mem_lo};
        end else if (wb_whilo) begin
            {cur_hi, cur_lo} = {wb_hi, wb_lo};
        end else begin
            {cur_hi, cur_lo} = {hi, lo};
        end
    end

    always_comb begin
        case (op)
            op_mfhi:          move_res = cur_hi;
            op_mflo:          move_res = cur_lo;
            op_movz, op_movn: move_res = reg1;        // condition decided by caller
            default:          move_res = '0;
        endcase
    end

    always_comb begin
        whilo   = 1'b1;
        hi_next = '0;
        lo_next = '0;
        case (op)
            op_mult, op_multu: {hi_next, lo_next} = product;
            op_mthi:           {hi_next, lo_next} = {reg1, cur_lo};   // lo kept
            op_mtlo:           {hi_next, lo_next} = {cur_hi, reg1};   // hi kept
            default:           whilo = 1'b0;
        endcase
    end

endmodule

// File: hw/ex_stage.sv
module ex_stage
    import ex_pkg::*;
(
    input  alu_op_e                   op,
    input  logic [word_width-1:0]     reg1,
    input  logic [word_width-1:0]     reg2,
    input  logic [reg_addr_width-1:0] waddr,
    input  logic                      wreg,
    input  logic                      mem_whilo,
    input  logic [word_width-1:0]     mem_hi,
    input  logic [word_width-1:0]     mem_lo,
    input  logic                      wb_whilo,
    input  logic [word_width-1:0]     wb_hi,
    input  logic [word_width-1:0]     wb_lo,
    input  logic [word_width-1:0]     hi,
    input  logic [word_width-1:0]     lo,
    output logic [reg_addr_width-1:0] ex_waddr,
    output logic                      ex_wreg,
    output logic [word_width-1:0]     ex_wdata,
    output logic                      ex_whilo,
    output logic [word_width-1:0]     ex_hi,
    output logic [word_width-1:0]     ex_lo
);

    logic [word_width-1:0]  arith_res;
    logic                   overflow;
    logic [word_width-1:0]  bit_res;
    logic [dword_width-1:0] product;
    logic [word_width-1:0]  move_res;
    res_group_e             res_group;

    ex_arith u_arith (.op(op), .reg1(reg1), .reg2(reg2),
                      .arith_res(arith_res), .overflow(overflow));

    ex_bitwise u_bitwise (.op(op), .reg1(reg1), .reg2(reg2), .bit_res(bit_res));

    ex_mul u_mul (.op(op), .reg1(reg1), .reg2(reg2), .product(product));

    ex_hilo u_hilo (
        .op(op), .reg1(reg1), .product(product),
        .mem_whilo(mem_whilo), .mem_hi(mem_hi), .mem_lo(mem_lo),
        .wb_whilo(wb_whilo), .wb_hi(wb_hi), .wb_lo(wb_lo),
        .hi(hi), .lo(lo),
        .move_res(move_res), .whilo(ex_whilo), .hi_next(ex_hi), .lo_next(ex_lo)
    );

    assign res_group = op_group(op);
    assign ex_waddr  = waddr;

    // a bubble never writes, signed overflow cancels the write
    assign ex_wreg = wreg && (op != op_nop) &&
                     !(((op == op_add) || (op == op_sub)) && overflow);

    always_comb begin
        case (res_group)
            grp_logic, grp_shift: ex_wdata = bit_res;
            grp_arith:            ex_wdata = arith_res;
            grp_move:             ex_wdata = move_res;
            grp_mul:              ex_wdata = product[word_width-1:0];   // low word
            default:              ex_wdata = '0;
        endcase
    end

endmodule

// File: hw/stage_reg.sv
module stage_reg
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      d_wreg,
    input  logic [reg_addr_width-1:0] d_waddr,
    input  logic [word_width-1:0]     d_wdata,
    input  logic                      d_whilo,
    input  logic [word_width-1:0]     d_hi,
    input  logic [word_width-1:0]     d_lo,
    output logic                      q_wreg,
    output logic [reg_addr_width-1:0] q_waddr,
    output logic [word_width-1:0]     q_wdata,
    output logic                      q_whilo,
    output logic [word_width-1:0]     q_hi,
    output logic [word_width-1:0]     q_lo
);

    always_ff @(posedge clk) begin
        if (reset) begin
            q_wreg  <= 1'b0;
            q_waddr <= '0;
            q_wdata <= '0;
            q_whilo <= 1'b0;
            q_hi    <= '0;
            q_lo    <= '0;
        end else begin
            q_wreg  <= d_wreg;
            q_waddr <= d_waddr;
            q_wdata <= d_wdata;
            q_whilo <= d_whilo;
            q_hi    <= d_hi;
            q_lo    <= d_lo;
        end
    end

endmodule

// File: hw/hilo_reg.sv
module hilo_reg
    import ex_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  whilo,
    input  logic [word_width-1:0] hi_in,
    input  logic [word_width-1:0] lo_in,
    output logic [word_width-1:0] hi,
    output logic [word_width-1:0] lo
);

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (whilo) begin
            hi <= hi_in;        // both halves always written together
            lo <= lo_in;
        end
    end

endmodule

// File: hw/ex_pipe_top.sv
module ex_pipe_top
    import ex_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  alu_op_e                   op,
    input  logic [word_width-1:0]     reg1,
    input  logic [word_width-1:0]     reg2,
    input  logic [reg_addr_width-1:0] waddr,
    input  logic                      wreg,
    output logic                      wb_wreg,
    output logic [reg_addr_width-1:0] wb_waddr,
    output logic [word_width-1:0]     wb_wdata,
    output logic [word_width-1:0]     hi,
    output logic [word_width-1:0]     lo
);

    // ====================
    // stage outputs
    // ====================
    logic                      ex_wreg,  mem_wreg;
    logic [reg_addr_width-1:0] ex_waddr, mem_waddr;
    logic [word_width-1:0]     ex_wdata, mem_wdata;
    logic                      ex_whilo, mem_whilo, wb_whilo;
    logic [word_width-1:0]     ex_hi,    mem_hi,    wb_hi;
    logic [word_width-1:0]     ex_lo,    mem_lo,    wb_lo;

    ex_stage u_ex (
        .op(op), .reg1(reg1), .reg2(reg2), .waddr(waddr), .wreg(wreg),
        .mem_whilo(mem_whilo), .mem_hi(mem_hi), .mem_lo(mem_lo),
        .wb_whilo(wb_whilo), .wb_hi(wb_hi), .wb_lo(wb_lo),
        .hi(hi), .lo(lo),
        .ex_waddr(ex_waddr), .ex_wreg(ex_wreg), .ex_wdata(ex_wdata),
        .ex_whilo(ex_whilo), .ex_hi(ex_hi), .ex_lo(ex_lo)
    );

    stage_reg u_mem (
        .clk(clk), .reset(reset),
        .d_wreg(ex_wreg), .d_waddr(ex_waddr), .d_wdata(ex_wdata),
        .d_whilo(ex_whilo), .d_hi(ex_hi), .d_lo(ex_lo),
        .q_wreg(mem_wreg), .q_waddr(mem_waddr), .q_wdata(mem_wdata),
        .q_whilo(mem_whilo), .q_hi(mem_hi), .q_lo(mem_lo)
    );

    stage_reg u_wb (
        .clk(clk), .reset(reset),
        .d_wreg(mem_wreg), .d_waddr(mem_waddr), .d_wdata(mem_wdata),
        .d_whilo(mem_whilo), .d_hi(mem_hi), .d_lo(mem_lo),
        .q_wreg(wb_wreg), .q_waddr(wb_waddr), .q_wdata(wb_wdata),
        .q_whilo(wb_whilo), .q_hi(wb_hi), .q_lo(wb_lo)
    );

    hilo_reg u_hilo (
        .clk(clk), .reset(reset),
        .whilo(wb_whilo), .hi_in(wb_hi), .lo_in(wb_lo),
        .hi(hi), .lo(lo)
    );

endmodule

// File: verif/ex_pipe_properties.sv
module ex_pipe_properties
    import ex_pkg::*;
(
    input logic                  clk,
    input logic                  reset,
    input alu_op_e               op,
    input logic                  ex_wreg,
    input logic                  wb_wreg,
    input logic                  wb_whilo,
    input logic [word_width-1:0] hi,
    input logic [word_width-1:0] lo
);

    timeunit 1ns;
    timeprecision 100ps;

    int assert_failures = 0;

    wb_wreg_after_reset: assert property (@(posedge clk) reset |=> !wb_wreg)
        else begin
            $error("wb_wreg high in the cycle after reset");
            assert_failures++;
        end

    // hilo_reg only loads from a writeback with whilo set
    hilo_only_on_whilo: assert property (@(posedge clk)
        (!reset && !wb_whilo) |=> ($stable(hi) && $stable(lo)))
        else begin
            $error("hi/lo changed without a HI/LO write in writeback");
            assert_failures++;
        end

    nop_no_write: assert property (@(posedge clk) (op == op_nop) |-> !ex_wreg)
        else begin
            $error("ex_wreg high for a nop");
            assert_failures++;
        end

endmodule

bind ex_pipe_top ex_pipe_properties u_props (
    .clk(clk), .reset(reset), .op(op), .ex_wreg(ex_wreg), .wb_wreg(wb_wreg),
    .wb_whilo(wb_whilo), .hi(hi), .lo(lo)
);

// File: verif/ex_pipe_tb.sv
module ex_pipe_tb
    import ex_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    num_vectors  = 39;
    localparam int    num_fields   = 9;
    localparam string data_file    = "verif/ex_testdata.txt";
    localparam int    clk_period   = 4;
    localparam int    reset_cycles = 10;
    localparam int    drive_delay  = 1;
    localparam int    timeout_ns   = (num_vectors + 20) * clk_period + reset_cycles * clk_period;

    logic                      clk = 1'b0;
    logic                      reset;
    alu_op_e                   op;
    logic [word_width-1:0]     reg1;
    logic [word_width-1:0]     reg2;
    logic [reg_addr_width-1:0] waddr;
    logic                      wreg;
    logic                      wb_wreg;
    logic [reg_addr_width-1:0] wb_waddr;
    logic [word_width-1:0]     wb_wdata;
    logic [word_width-1:0]     hi;
    logic [word_width-1:0]     lo;

    logic [31:0] vec_mem [0:num_vectors*num_fields-1];
    int          test_err [0:num_vectors-1];
    int          error_count = 0;
    int          pass_count  = 0;
    int          fail_count  = 0;

    ex_pipe_top DUT (
        .clk(clk), .reset(reset), .op(op), .reg1(reg1), .reg2(reg2),
        .waddr(waddr), .wreg(wreg),
        .wb_wreg(wb_wreg), .wb_waddr(wb_waddr), .wb_wdata(wb_wdata), .hi(hi), .lo(lo)
    );

    always #(clk_period / 2) clk = ~clk;

    // ====================
    // vector access
    // ====================
    function automatic logic [31:0] field(input int v, input int f);
        return vec_mem[v * num_fields + f];
    endfunction

    function automatic string test_name(input int v);
        logic [31:0] w;
        alu_op_e     vop;
        w   = field(v, 0);
        vop = alu_op_e'(w[7:0]);
        return $sformatf("vec%0d_%s", v, vop.name());
    endfunction

    task automatic drive_idle();
        op    = op_nop;
        reg1  = '0;
        reg2  = '0;
        waddr = '0;
        wreg  = 1'b1;        // bubble with a stale enable
    endtask

    task automatic apply_vector(input int v);
        logic [31:0] w_op;
        logic [31:0] w_addr;
        logic [31:0] w_wreg;
        w_op   = field(v, 0);
        w_addr = field(v, 3);
        w_wreg = field(v, 4);
        op     = alu_op_e'(w_op[7:0]);
        reg1   = field(v, 1);
        reg2   = field(v, 2);
        waddr  = w_addr[reg_addr_width-1:0];
        wreg   = w_wreg[0];
    endtask

    // ====================
    // checks
    // ====================
    task automatic check_register(input int v);
        logic [31:0] exp_wreg;
        logic [31:0] exp_wdata;
        logic [31:0] exp_addr;
        exp_wreg  = field(v, 5);
        exp_wdata = field(v, 6);
        exp_addr  = field(v, 3);
        if (wb_wreg !== exp_wreg[0]) begin
            $display("CHECK FAILED %s wb_wreg expected %0b actual %0b",
                     test_name(v), exp_wreg[0], wb_wreg);
            test_err[v]++;
        end
        if (exp_wreg[0] && (wb_wdata !== exp_wdata)) begin
            $display("CHECK FAILED %s wb_wdata expected %h actual %h",
                     test_name(v), exp_wdata, wb_wdata);
            test_err[v]++;
        end
        if (exp_wreg[0] && (wb_waddr !== exp_addr[reg_addr_width-1:0])) begin
            $display("CHECK FAILED %s wb_waddr expected %h actual %h",
                     test_name(v), exp_addr[reg_addr_width-1:0], wb_waddr);
            test_err[v]++;
        end
    endtask

    task automatic check_hilo(input int v);
        logic [31:0] exp_hi;
        logic [31:0] exp_lo;
        exp_hi = field(v, 7);
        exp_lo = field(v, 8);
        if (hi !== exp_hi) begin
            $display("CHECK FAILED %s hi expected %h actual %h", test_name(v), exp_hi, hi);
            test_err[v]++;
        end
        if (lo !== exp_lo) begin
            $display("CHECK FAILED %s lo expected %h actual %h", test_name(v), exp_lo, lo);
            test_err[v]++;
        end
    endtask

    task automatic report_test(input int v);
        if (test_err[v] == 0) begin
            $display("PASS %s", test_name(v));
            pass_count++;
        end else begin
            $display("FAIL %s", test_name(v));
            fail_count++;
            error_count += test_err[v];
        end
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        if (wb_wreg !== 1'b0) begin
            $display("CHECK FAILED reset_state wb_wreg expected 0 actual %0b", wb_wreg);
            errs++;
        end
        if ((hi !== '0) || (lo !== '0)) begin
            $display("CHECK FAILED reset_state hi/lo expected %h actual %h",
                     64'h0, {hi, lo});
            errs++;
        end
        if (errs == 0) begin
            $display("PASS reset_state");
            pass_count++;
        end else begin
            $display("FAIL reset_state");
            fail_count++;
            error_count += errs;
        end
    endtask

    // one vector per cycle, wb checked 2 cycles on, hi/lo 3 cycles on
    task automatic run_vectors();
        for (int j = 0; j < num_vectors + 3; j++) begin
            @(posedge clk);
            #drive_delay;
            if ((j >= 2) && (j - 2 < num_vectors)) begin
                check_register(j - 2);
            end
            if (j >= 3) begin
                check_hilo(j - 3);
                report_test(j - 3);
            end
            if (j < num_vectors) begin
                apply_vector(j);
            end else begin
                drive_idle();
            end
        end
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        int fd;
        bit file_ok;
        drive_idle();
        reset   = 1'b1;
        fd      = $fopen(data_file, "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            $fclose(fd);
            $readmemh(data_file, vec_mem);
        end else begin
            $display("could not open the test data file %s", data_file);
            error_count++;
        end
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        check_reset_state();
        if (file_ok) begin
            run_vectors();
        end
        error_count += DUT.u_props.assert_failures;
        $display("summary: %0d passed, %0d failed, %0d assertion failures, %0d errors",
                 pass_count, fail_count, DUT.u_props.assert_failures, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #timeout_ns;
        $display("watchdog expired before all tests finished");
        $display("Errors found");
        $finish;
    end

endmodule

// File: verif/ex_testdata.txt
// op reg1 reg2 waddr wreg : expected wb_wreg wb_wdata hi lo
// hi and lo are the HI/LO pair once the vector has retired
01 f0f0ff00 ff00f0f0 01 1 1 f000f000 00000000 00000000
02 f0f0ff00 ff00f0f0 02 1 1 fff0fff0 00000000 00000000
03 f0f0ff00 ff00f0f0 03 1 1 0ff00ff0 00000000 00000000
04 f0f0ff00 ff00f0f0 04 1 1 000f000f 00000000 00000000
05 00000000 12345678 05 1 1 12345678 00000000 00000000
05 00000001 80000001 06 1 1 00000002 00000000 00000000
05 0000001f 00000003 07 1 1 80000000 00000000 00000000
06 00000001 80000000 08 1 1 40000000 00000000 00000000
06 0000001f 80000000 09 1 1 00000001 00000000 00000000
07 00000001 80000000 0a 1 1 c0000000 00000000 00000000
07 0000001f 80000000 0b 1 1 ffffffff 00000000 00000000
07 00000020 f0000000 0c 1 1 f0000000 00000000 00000000
08 00000005 fffffffd 0d 1 1 00000002 00000000 00000000
08 7fffffff 00000001 0e 1 0 00000000 00000000 00000000
09 7fffffff 00000001 0f 1 1 80000000 00000000 00000000
0a 00000003 00000005 10 1 1 fffffffe 00000000 00000000
0a 80000000 00000001 11 1 0 00000000 00000000 00000000
0b 80000000 00000001 12 1 1 7fffffff 00000000 00000000
0c ffffffff 00000001 13 1 1 00000001 00000000 00000000
0d ffffffff 00000001 14 1 1 00000000 00000000 00000000
0e 00000000 00000000 15 1 1 00000020 00000000 00000000
0e ffffffff 00000000 16 1 1 00000000 00000000 00000000
0e 00010000 00000000 17 1 1 0000000f 00000000 00000000
0f ffffffff 00000000 18 1 1 00000020 00000000 00000000
0f 00000000 00000000 19 1 1 00000000 00000000 00000000
0f 80000000 00000000 1a 1 1 00000001 00000000 00000000
10 fffffffd 00000007 1b 1 1 ffffffeb 00000000 00000000
11 fffffffe 00000003 00 0 0 00000000 ffffffff fffffffa
13 00000000 00000000 1c 1 1 ffffffff ffffffff fffffffa
14 00000000 00000000 1d 1 1 fffffffa ffffffff fffffffa
12 ffffffff 00000002 00 0 0 00000000 00000001 fffffffe
15 12345678 00000000 00 0 0 00000000 12345678 fffffffe
13 00000000 00000000 1e 1 1 12345678 12345678 fffffffe
16 9abcdef0 00000000 00 0 0 00000000 12345678 9abcdef0
02 00000001 00000002 1f 1 1 00000003 12345678 9abcdef0
14 00000000 00000000 01 1 1 9abcdef0 12345678 9abcdef0
17 aaaa5555 00000000 02 1 1 aaaa5555 12345678 9abcdef0
18 0000beef 00000001 03 1 1 0000beef 12345678 9abcdef0
00 00000000 00000000 00 0 0 00000000 12345678 9abcdef0

// File: all.f
hw/ex_pkg.sv
hw/ex_arith.sv
hw/ex_bitwise.sv
hw/ex_mul.sv
hw/ex_hilo.sv
hw/ex_stage.sv
hw/stage_reg.sv
hw/hilo_reg.sv
hw/ex_pipe_top.sv
verif/ex_pipe_properties.sv
verif/ex_pipe_tb.sv

// File: Makefile
# Verilator build and run for the execute-stage pipeline

VERILATOR ?= verilator
TOP       ?= ex_pipe_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= No errors

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	-$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
